//--- files.f
design/exec_pkg.sv
design/exec_alu.sv
design/exec_multiply.sv
design/exec_divide.sv
design/exec_control.sv
design/exec_top.sv
tests/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - design/exec_pkg.sv
      - design/exec_alu.sv
      - design/exec_multiply.sv
      - design/exec_divide.sv
      - design/exec_control.sv
      - design/exec_top.sv
  - target: test
    files:
      - tests/exec_tb.sv

//--- tests/exec_tb.sv
// Execute stage testbench
module exec_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MUL_STAGES = 2;
	localparam int CLOCK_PERIOD = 20;
	localparam int WAIT_LIMIT = 64;
	localparam int INSTR_COUNT = 125;
	localparam int WATCHDOG_CYCLES = INSTR_COUNT * 40 + 500;

	logic clock;
	logic reset;
	exec_pkg::exec_issue_t issue;
	logic memory_busy;
	logic busy;
	exec_pkg::exec_result_t result;
	logic jump;
	logic [31:0] jump_pc;
	logic fault;

	logic [31:0] lcg_state = 32'hc513;
	int error_count = 0;
	int check_count = 0;
	logic strobe_before;
	logic muldiv_pending;

	exec_top #(
		.MUL_STAGES(MUL_STAGES)
	) dut_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_issue(issue),
		.i_memory_busy(memory_busy),
		.o_busy(busy),
		.o_result(result),
		.o_jump(jump),
		.o_jump_pc(jump_pc),
		.o_fault(fault)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("sim failed");
		$finish;
	end

	// ============================================================
	// Reference models
	// ============================================================

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic branch_taken(exec_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
		case (op)
		exec_pkg::ALU_EQ: return a == b;
		exec_pkg::ALU_NE: return a != b;
		exec_pkg::ALU_LT: return $signed(a) < $signed(b);
		exec_pkg::ALU_LTU: return a < b;
		exec_pkg::ALU_GE: return $signed(a) >= $signed(b);
		exec_pkg::ALU_GEU: return a >= b;
		default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_reference(exec_pkg::alu_op_e op, logic [31:0] a,
		logic [31:0] b);
		logic [4:0] shamt;
		shamt = b[4:0];
		case (op)
		exec_pkg::ALU_ADD: return a + b;
		exec_pkg::ALU_SUB: return a - b;
		exec_pkg::ALU_AND: return a & b;
		exec_pkg::ALU_OR: return a | b;
		exec_pkg::ALU_XOR: return a ^ b;
		exec_pkg::ALU_SLL: return a << shamt;
		exec_pkg::ALU_SRL: return a >> shamt;
		exec_pkg::ALU_SRA: return $signed(a) >>> shamt;
		// Set-less-than style, rd gets 0 or 1
		default: return {31'b0, branch_taken(op, a, b)};
		endcase
	endfunction

	function automatic logic [31:0] muldiv_reference(exec_pkg::muldiv_op_e op, logic [31:0] a,
		logic [31:0] b);
		logic signed [63:0] product_signed;
		logic [63:0] product_unsigned;
		logic overflow;
		product_signed = $signed(a) * $signed(b);
		product_unsigned = {32'b0, a} * {32'b0, b};
		overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
		exec_pkg::MD_MUL: return product_signed[31:0];
		exec_pkg::MD_MULH: return product_signed[63:32];
		exec_pkg::MD_MULHU: return product_unsigned[63:32];
		exec_pkg::MD_DIV: begin
			if (b == 32'b0) return 32'hffff_ffff;
			if (overflow) return a;
			return $signed(a) / $signed(b);
		end
		exec_pkg::MD_DIVU: return (b == 32'b0) ? 32'hffff_ffff : a / b;
		exec_pkg::MD_REM: begin
			if (b == 32'b0) return a;
			if (overflow) return 32'b0;
			return $signed(a) % $signed(b);
		end
		default: return (b == 32'b0) ? a : a % b;
		endcase
	endfunction

	function automatic logic [31:0] operand_value(exec_pkg::operand_sel_e sel,
		exec_pkg::exec_issue_t word);
		case (sel)
		exec_pkg::SEL_RS1: return word.rs1;
		exec_pkg::SEL_RS2: return word.rs2;
		exec_pkg::SEL_PC: return word.pc;
		exec_pkg::SEL_IMM: return word.imm;
		default: return 32'b0;
		endcase
	endfunction

	function automatic exec_pkg::exec_issue_t make_issue(exec_pkg::exec_class_e op_class,
		exec_pkg::alu_op_e alu_op, exec_pkg::operand_sel_e op1_sel,
		exec_pkg::operand_sel_e op2_sel);
		exec_pkg::exec_issue_t word;
		logic [31:0] rd_bits;
		word = '0;
		word.pc = next_random() & 32'hffff_fffc;
		word.imm = next_random();
		word.rs1 = next_random();
		word.rs2 = next_random();
		rd_bits = next_random();
		word.rd = rd_bits[20:16];
		word.op_class = op_class;
		word.alu_op = alu_op;
		word.op1_sel = op1_sel;
		word.op2_sel = op2_sel;
		return word;
	endfunction

	// ============================================================
	// Driving and checking
	// ============================================================

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		issue <= '0;
		memory_busy <= 1'b0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
	endtask

	// New instruction is a toggle of the issue strobe
	task automatic drive_issue(input exec_pkg::exec_issue_t word);
		strobe_before = result.strobe;
		muldiv_pending = (word.op_class == exec_pkg::CLASS_MULDIV);
		@(posedge clock);
		word.strobe = !issue.strobe;
		issue <= word;
	endtask

	// Counts rising edges from the issue edge up to the result toggle
	task automatic wait_result(output int cycles);
		cycles = 0;
		while (cycles < WAIT_LIMIT) begin
			@(negedge clock);
			if (result.strobe != strobe_before) break;
			check_value("o_busy", busy, muldiv_pending);
			cycles++;
		end
		if (result.strobe == strobe_before) begin
			$display("Result strobe did not toggle within %0d cycles", WAIT_LIMIT);
			error_count++;
		end
		check_value("o_busy", busy, 1'b0);
	endtask

	task automatic jump_pulse(input logic [31:0] target);
		check_value("o_jump", jump, 1'b1);
		check_value("o_jump_pc", jump_pc, target);
		@(negedge clock);
		check_value("o_jump", jump, 1'b0);
	endtask

	// ============================================================
	// Behaviors
	// ============================================================

	task automatic reset_values();
		check_value("o_jump", jump, 1'b0);
		check_value("o_fault", fault, 1'b0);
		check_value("o_result.strobe", result.strobe, 1'b0);
		check_value("o_busy", busy, 1'b0);
	endtask

	task automatic alu_sweep();
		exec_pkg::exec_issue_t word;
		exec_pkg::alu_op_e op;
		exec_pkg::exec_class_e op_class;
		exec_pkg::operand_sel_e sel1;
		exec_pkg::operand_sel_e sel2;
		logic [31:0] expected;
		int cycles;
		for (int k = exec_pkg::ALU_ADD; k <= exec_pkg::ALU_GEU; k++) begin
			op = exec_pkg::alu_op_e'(k);
			if (k <= exec_pkg::ALU_XOR) op_class = exec_pkg::CLASS_ARITH;
			else if (k <= exec_pkg::ALU_SRA) op_class = exec_pkg::CLASS_SHIFT;
			else op_class = exec_pkg::CLASS_COMPARE;
			for (int s = 0; s < 5; s++) begin
				sel1 = exec_pkg::operand_sel_e'(s);
				sel2 = exec_pkg::operand_sel_e'((s + 1 + k) % 5);
				word = make_issue(op_class, op, sel1, sel2);
				expected = alu_reference(op, operand_value(sel1, word), operand_value(sel2, word));
				drive_issue(word);
				wait_result(cycles);
				check_value("result latency", cycles, 1);
				check_value("o_result.rd", result.rd, word.rd);
				check_value("o_result.rd_value", result.rd_value, expected);
				check_value("o_jump", jump, 1'b0);
			end
		end
	endtask

	task automatic redirect_cases();
		exec_pkg::exec_issue_t word;
		exec_pkg::alu_op_e op;
		logic taken;
		int cycles;
		word = make_issue(exec_pkg::CLASS_JUMP, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		drive_issue(word);
		wait_result(cycles);
		check_value("o_result.rd_value", result.rd_value, word.pc + 32'd4);
		jump_pulse(word.rs1 + word.imm);
		for (int k = exec_pkg::ALU_EQ; k <= exec_pkg::ALU_GEU; k++) begin
			for (int trial = 0; trial < 2; trial++) begin
				op = exec_pkg::alu_op_e'(k);
				word = make_issue(exec_pkg::CLASS_BRANCH, op, exec_pkg::SEL_RS1,
					exec_pkg::SEL_RS2);
				// Equal operands give both outcomes across the six compares
				if (trial == 0) word.rs2 = word.rs1;
				taken = branch_taken(op, word.rs1, word.rs2);
				drive_issue(word);
				wait_result(cycles);
				check_value("result latency", cycles, 1);
				jump_pulse(taken ? word.pc + word.imm : word.pc + 32'd4);
			end
		end
	endtask

	task automatic memory_access();
		exec_pkg::exec_issue_t word;
		int cycles;
		for (int w = 0; w < 3; w++) begin
			word = make_issue(exec_pkg::CLASS_LOAD, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
				exec_pkg::SEL_IMM);
			word.mem_width = exec_pkg::mem_width_e'(w);
			word.mem_signed = word.imm[20];
			drive_issue(word);
			wait_result(cycles);
			check_value("o_result.mem_read", result.mem_read, 1'b1);
			check_value("o_result.mem_write", result.mem_write, 1'b0);
			check_value("o_result.mem_address", result.mem_address, word.rs1 + word.imm);
			check_value("o_result.mem_width", result.mem_width, word.mem_width);
			check_value("o_result.mem_signed", result.mem_signed, word.mem_signed);
		end
		word = make_issue(exec_pkg::CLASS_STORE, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		word.mem_width = exec_pkg::MEM_HALF;
		drive_issue(word);
		wait_result(cycles);
		check_value("o_result.mem_write", result.mem_write, 1'b1);
		check_value("o_result.mem_read", result.mem_read, 1'b0);
		check_value("o_result.mem_address", result.mem_address, word.rs1 + word.imm);
		check_value("o_result.rd_value", result.rd_value, word.rs2);
		check_value("o_result.mem_width", result.mem_width, exec_pkg::MEM_HALF);
		// Load held back by a busy memory stage
		@(posedge clock);
		memory_busy <= 1'b1;
		word = make_issue(exec_pkg::CLASS_LOAD, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		drive_issue(word);
		repeat (6) begin
			@(negedge clock);
			check_value("o_result.strobe", result.strobe, strobe_before);
		end
		@(posedge clock);
		memory_busy <= 1'b0;
		wait_result(cycles);
		check_value("release latency", cycles, 1);
		check_value("o_result.mem_address", result.mem_address, word.rs1 + word.imm);
	endtask

	task automatic muldiv_one(input exec_pkg::muldiv_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		exec_pkg::exec_issue_t word;
		int cycles;
		word = make_issue(exec_pkg::CLASS_MULDIV, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		word.muldiv_op = op;
		word.rs1 = a;
		word.rs2 = b;
		drive_issue(word);
		wait_result(cycles);
		check_value("o_result.rd", result.rd, word.rd);
		check_value("o_result.rd_value", result.rd_value, muldiv_reference(op, a, b));
		if (op inside {exec_pkg::MD_MUL, exec_pkg::MD_MULH, exec_pkg::MD_MULHU}) begin
			check_value("multiply latency", cycles, MUL_STAGES + 1);
		end
	endtask

	task automatic muldiv_cases();
		exec_pkg::muldiv_op_e op;
		for (int k = exec_pkg::MD_MUL; k <= exec_pkg::MD_REMU; k++) begin
			op = exec_pkg::muldiv_op_e'(k);
			repeat (3) muldiv_one(op, next_random(), next_random());
		end
		// Divide by zero, then the signed overflow pair
		for (int k = exec_pkg::MD_DIV; k <= exec_pkg::MD_REMU; k++) begin
			op = exec_pkg::muldiv_op_e'(k);
			muldiv_one(op, next_random(), 32'b0);
			muldiv_one(op, 32'h8000_0000, 32'hffff_ffff);
		end
	endtask

	task automatic fault_sticky();
		exec_pkg::exec_issue_t word;
		int cycles;
		word = make_issue(exec_pkg::CLASS_NONE, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		drive_issue(word);
		wait_result(cycles);
		check_value("o_fault", fault, 1'b1);
		repeat (2) begin
			word = make_issue(exec_pkg::CLASS_ARITH, exec_pkg::ALU_XOR, exec_pkg::SEL_RS1,
				exec_pkg::SEL_RS2);
			drive_issue(word);
			wait_result(cycles);
			check_value("o_result.rd_value", result.rd_value, word.rs1 ^ word.rs2);
			check_value("o_fault", fault, 1'b1);
		end
		apply_reset();
		check_value("o_fault", fault, 1'b0);
		check_value("o_result.strobe", result.strobe, 1'b0);
		word = make_issue(exec_pkg::CLASS_ARITH, exec_pkg::ALU_SUB, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		drive_issue(word);
		wait_result(cycles);
		check_value("o_result.rd_value", result.rd_value, word.rs1 - word.rs2);
		check_value("o_fault", fault, 1'b0);
	endtask

	// ============================================================
	// Sequence
	// ============================================================

	initial begin
		reset = 1'b1;
		issue = '0;
		memory_busy = 1'b0;
		apply_reset();
		reset_values();
		alu_sweep();
		redirect_cases();
		memory_access();
		muldiv_cases();
		fault_sticky();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- design/exec_top.sv
// Execute stage top level
module exec_top #(
	parameter int MUL_STAGES = exec_pkg::MUL_STAGES_DEFAULT
) (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::exec_issue_t i_issue,
	input logic i_memory_busy,
	output logic o_busy,
	output exec_pkg::exec_result_t o_result,
	output logic o_jump,
	output logic [exec_pkg::XLEN-1:0] o_jump_pc,
	output logic o_fault
);

	exec_pkg::alu_op_e alu_op;
	logic [exec_pkg::XLEN-1:0] alu_op1;
	logic [exec_pkg::XLEN-1:0] alu_op2;
	logic [exec_pkg::XLEN-1:0] alu_result;
	logic [exec_pkg::XLEN-1:0] alu_sum;
	logic alu_compare;

	exec_pkg::muldiv_req_t muldiv_req;
	logic mul_start;
	logic div_start;
	logic mul_high;
	logic mul_ready;
	logic [exec_pkg::XLEN-1:0] mul_result;
	logic div_ready;
	logic [exec_pkg::XLEN-1:0] div_quotient;
	logic [exec_pkg::XLEN-1:0] div_remainder;

	exec_control control_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_issue(i_issue),
		.i_memory_busy(i_memory_busy),
		.o_busy(o_busy),
		.o_result(o_result),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault),
		.o_alu_op(alu_op),
		.o_alu_op1(alu_op1),
		.o_alu_op2(alu_op2),
		.i_alu_result(alu_result),
		.i_alu_sum(alu_sum),
		.i_alu_compare(alu_compare),
		.o_mul_start(mul_start),
		.o_div_start(div_start),
		.o_high(mul_high),
		.o_muldiv_req(muldiv_req),
		.i_mul_ready(mul_ready),
		.i_mul_result(mul_result),
		.i_div_ready(div_ready),
		.i_div_quotient(div_quotient),
		.i_div_remainder(div_remainder)
	);

	exec_alu alu_i (
		.i_op(alu_op),
		.i_op1(alu_op1),
		.i_op2(alu_op2),
		.o_result(alu_result),
		.o_sum(alu_sum),
		.o_compare(alu_compare)
	);

	exec_multiply #(
		.MUL_STAGES(MUL_STAGES)
	) multiply_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(mul_start),
		.i_req(muldiv_req),
		.i_high(mul_high),
		.o_ready(mul_ready),
		.o_result(mul_result)
	);

	exec_divide divide_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(div_start),
		.i_req(muldiv_req),
		.o_ready(div_ready),
		.o_quotient(div_quotient),
		.o_remainder(div_remainder)
	);

endmodule

//--- design/exec_control.sv
// Execute stage control
module exec_control (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::exec_issue_t i_issue,
	input logic i_memory_busy,
	output logic o_busy,
	output exec_pkg::exec_result_t o_result,
	output logic o_jump,
	output logic [exec_pkg::XLEN-1:0] o_jump_pc,
	output logic o_fault,

	// ALU
	output exec_pkg::alu_op_e o_alu_op,
	output logic [exec_pkg::XLEN-1:0] o_alu_op1,
	output logic [exec_pkg::XLEN-1:0] o_alu_op2,
	input logic [exec_pkg::XLEN-1:0] i_alu_result,
	input logic [exec_pkg::XLEN-1:0] i_alu_sum,
	input logic i_alu_compare,

	// Multiply and divide units
	output logic o_mul_start,
	output logic o_div_start,
	output logic o_high,
	output exec_pkg::muldiv_req_t o_muldiv_req,
	input logic i_mul_ready,
	input logic [exec_pkg::XLEN-1:0] i_mul_result,
	input logic i_div_ready,
	input logic [exec_pkg::XLEN-1:0] i_div_quotient,
	input logic [exec_pkg::XLEN-1:0] i_div_remainder
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_MUL,
		ST_WAIT_DIV
	} state_e;

	state_e state_q;
	logic last_strobe_q;
	logic pending;
	logic is_muldiv;
	logic is_mul;
	logic is_rem;
	logic is_redirect;
	logic complete;
	logic [exec_pkg::XLEN-1:0] pc_plus_4;
	logic [exec_pkg::XLEN-1:0] pc_plus_imm;
	exec_pkg::exec_result_t result_next;

	function automatic logic [exec_pkg::XLEN-1:0] select_operand(
		exec_pkg::operand_sel_e sel,
		exec_pkg::exec_issue_t issue
	);
		case (sel)
		exec_pkg::SEL_RS1: return issue.rs1;
		exec_pkg::SEL_RS2: return issue.rs2;
		exec_pkg::SEL_PC: return issue.pc;
		exec_pkg::SEL_IMM: return issue.imm;
		default: return '0;
		endcase
	endfunction

	// ============================================================
	// Decode of the pending issue
	// ============================================================

	assign pending = (i_issue.strobe != last_strobe_q);
	assign is_muldiv = (i_issue.op_class == exec_pkg::CLASS_MULDIV);
	assign is_mul = (i_issue.muldiv_op inside {exec_pkg::MD_MUL, exec_pkg::MD_MULH,
		exec_pkg::MD_MULHU});
	assign is_rem = (i_issue.muldiv_op inside {exec_pkg::MD_REM, exec_pkg::MD_REMU});
	assign is_redirect = (i_issue.op_class inside {exec_pkg::CLASS_JUMP,
		exec_pkg::CLASS_BRANCH});
	assign pc_plus_4 = i_issue.pc + 32'd4;
	assign pc_plus_imm = i_issue.pc + i_issue.imm;

	assign o_alu_op = i_issue.alu_op;
	assign o_alu_op1 = select_operand(i_issue.op1_sel, i_issue);
	assign o_alu_op2 = select_operand(i_issue.op2_sel, i_issue);

	assign o_busy = pending && is_muldiv;

	// Units are started only from idle, so exactly once per instruction
	assign o_muldiv_req.is_signed = (i_issue.muldiv_op inside {exec_pkg::MD_MUL,
		exec_pkg::MD_MULH, exec_pkg::MD_DIV, exec_pkg::MD_REM});
	assign o_muldiv_req.op1 = i_issue.rs1;
	assign o_muldiv_req.op2 = i_issue.rs2;
	assign o_high = (i_issue.muldiv_op != exec_pkg::MD_MUL);
	assign o_mul_start = pending && is_muldiv && is_mul && (state_q == ST_IDLE);
	assign o_div_start = pending && is_muldiv && !is_mul && (state_q == ST_IDLE);

	always_comb begin
		complete = 1'b0;
		if (pending && !i_memory_busy) begin
			case (state_q)
			ST_IDLE: complete = !is_muldiv;
			ST_WAIT_MUL: complete = i_mul_ready;
			ST_WAIT_DIV: complete = i_div_ready;
			default: complete = 1'b0;
			endcase
		end
	end

	// Next result word
	always_comb begin
		result_next.strobe = !o_result.strobe;
		result_next.rd = i_issue.rd;
		result_next.mem_read = (i_issue.op_class == exec_pkg::CLASS_LOAD);
		result_next.mem_write = (i_issue.op_class == exec_pkg::CLASS_STORE);
		result_next.mem_address = i_alu_sum;
		result_next.mem_width = i_issue.mem_width;
		result_next.mem_signed = i_issue.mem_signed;
		case (i_issue.op_class)
		exec_pkg::CLASS_ARITH,
		exec_pkg::CLASS_SHIFT,
		exec_pkg::CLASS_COMPARE: result_next.rd_value = i_alu_result;
		exec_pkg::CLASS_JUMP: result_next.rd_value = pc_plus_4;
		exec_pkg::CLASS_STORE: result_next.rd_value = i_issue.rs2;
		exec_pkg::CLASS_MULDIV: begin
			if (is_mul) begin
				result_next.rd_value = i_mul_result;
			end else begin
				result_next.rd_value = is_rem ? i_div_remainder : i_div_quotient;
			end
		end
		default: result_next.rd_value = '0;
		endcase
	end

	// ============================================================
	// State and outputs
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= ST_IDLE;
			last_strobe_q <= 1'b0;
			o_result <= '0;
			o_jump <= 1'b0;
			o_jump_pc <= '0;
			o_fault <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			if (o_mul_start) begin
				state_q <= ST_WAIT_MUL;
			end else if (o_div_start) begin
				state_q <= ST_WAIT_DIV;
			end
			if (complete) begin
				state_q <= ST_IDLE;
				last_strobe_q <= i_issue.strobe;
				o_result <= result_next;
				if (is_redirect) begin
					o_jump <= 1'b1;
					if (i_issue.op_class == exec_pkg::CLASS_JUMP) begin
						o_jump_pc <= i_alu_sum;
					end else begin
						o_jump_pc <= i_alu_compare ? pc_plus_imm : pc_plus_4;
					end
				end
				// Sticky until reset
				if (i_issue.op_class == exec_pkg::CLASS_NONE) begin
					o_fault <= 1'b1;
				end
			end
		end
	end

	// Upstream cannot present a new issue before it sees the result strobe
	assert property (@(posedge i_clock) disable iff (i_reset) o_jump |=> !o_jump);

	// Upstream holds the issue stable while a unit is busy with it
	assert property (@(posedge i_clock) disable iff (i_reset)
		(state_q != ST_IDLE) |-> pending);

endmodule

//--- design/exec_divide.sv
// Iterative restoring divider
module exec_divide (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input exec_pkg::muldiv_req_t i_req,
	output logic o_ready,
	output logic [exec_pkg::XLEN-1:0] o_quotient,
	output logic [exec_pkg::XLEN-1:0] o_remainder
);

	localparam int XLEN = exec_pkg::XLEN;
	localparam int COUNT_W = $clog2(XLEN);

	logic num_negative;
	logic den_negative;
	logic [XLEN-1:0] num_abs;
	logic [XLEN-1:0] den_abs;
	logic [XLEN:0] shifted;
	logic [XLEN:0] trial;

	logic running_q;
	logic [COUNT_W-1:0] count_q;
	logic [XLEN-1:0] quot_q;
	logic [XLEN-1:0] rem_q;
	logic [XLEN-1:0] den_q;
	logic [XLEN-1:0] num_orig_q;
	logic neg_quot_q;
	logic neg_rem_q;
	logic div_zero_q;
	logic overflow_q;

	assign num_negative = i_req.is_signed & i_req.op1[XLEN-1];
	assign den_negative = i_req.is_signed & i_req.op2[XLEN-1];
	assign num_abs = num_negative ? -i_req.op1 : i_req.op1;
	assign den_abs = den_negative ? -i_req.op2 : i_req.op2;

	// One shift-subtract step
	assign shifted = {rem_q, quot_q[XLEN-1]};
	assign trial = shifted - {1'b0, den_q};

	// ============================================================
	// Iteration control
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running_q <= 1'b0;
			count_q <= '0;
		end else if (i_start) begin
			running_q <= 1'b1;
			count_q <= '0;
		end else if (running_q) begin
			count_q <= count_q + 1'b1;
			if (count_q == COUNT_W'(XLEN - 1)) begin
				running_q <= 1'b0;
			end
		end
	end

	// ============================================================
	// Datapath
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			quot_q <= num_abs;
			rem_q <= '0;
			den_q <= den_abs;
			num_orig_q <= i_req.op1;
			neg_quot_q <= num_negative ^ den_negative;
			neg_rem_q <= num_negative;
			div_zero_q <= (i_req.op2 == '0);
			overflow_q <= i_req.is_signed && (i_req.op1 == {1'b1, {(XLEN-1){1'b0}}})
				&& (i_req.op2 == '1);
		end else if (running_q) begin
			// Borrow out means the trial went negative, so restore
			if (trial[XLEN]) begin
				rem_q <= shifted[XLEN-1:0];
				quot_q <= {quot_q[XLEN-2:0], 1'b0};
			end else begin
				rem_q <= trial[XLEN-1:0];
				quot_q <= {quot_q[XLEN-2:0], 1'b1};
			end
		end
	end

	// RISC-V corner cases, then sign correction
	always_comb begin
		if (div_zero_q) begin
			o_quotient = '1;
			o_remainder = num_orig_q;
		end else if (overflow_q) begin
			o_quotient = num_orig_q;
			o_remainder = '0;
		end else begin
			o_quotient = neg_quot_q ? -quot_q : quot_q;
			o_remainder = neg_rem_q ? -rem_q : rem_q;
		end
	end

	assign o_ready = !running_q;

	// Control waits for ready before it can start another division
	assert property (@(posedge i_clock) disable iff (i_reset) running_q |-> !i_start);

endmodule

//--- design/exec_multiply.sv
// Pipelined multiplier
module exec_multiply #(
	parameter int MUL_STAGES = exec_pkg::MUL_STAGES_DEFAULT
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input exec_pkg::muldiv_req_t i_req,
	input logic i_high,
	output logic o_ready,
	output logic [exec_pkg::XLEN-1:0] o_result
);

	localparam int XLEN = exec_pkg::XLEN;

	logic signed [XLEN:0] op1_ext;
	logic signed [XLEN:0] op2_ext;
	logic signed [2*XLEN+1:0] product_full;
	logic [2*XLEN-1:0] stage_q [MUL_STAGES];
	logic [MUL_STAGES-1:0] valid_q;
	logic [MUL_STAGES:0] valid_chain;
	logic hold_q;

	// One extra bit turns mulhu into a signed multiply too
	assign op1_ext = {i_req.is_signed & i_req.op1[XLEN-1], i_req.op1};
	assign op2_ext = {i_req.is_signed & i_req.op2[XLEN-1], i_req.op2};
	assign product_full = op1_ext * op2_ext;

	// Stage s loads when its input carries a valid product
	assign valid_chain = {valid_q, i_start};

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			stage_q[0] <= product_full[2*XLEN-1:0];
		end
		for (int s = 1; s < MUL_STAGES; s++) begin
			if (valid_q[s-1]) begin
				stage_q[s] <= stage_q[s-1];
			end
		end
	end

	// Last stage keeps its product, ready holds until the next start
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid_q <= '0;
			hold_q <= 1'b0;
		end else begin
			valid_q <= valid_chain[MUL_STAGES-1:0];
			hold_q <= (hold_q | valid_q[MUL_STAGES-1]) & !i_start;
		end
	end

	assign o_ready = valid_q[MUL_STAGES-1] | hold_q;
	assign o_result = i_high ? stage_q[MUL_STAGES-1][2*XLEN-1:XLEN]
		: stage_q[MUL_STAGES-1][XLEN-1:0];

endmodule

//--- design/exec_alu.sv
// Integer ALU
module exec_alu (
	input exec_pkg::alu_op_e i_op,
	input logic [exec_pkg::XLEN-1:0] i_op1,
	input logic [exec_pkg::XLEN-1:0] i_op2,
	output logic [exec_pkg::XLEN-1:0] o_result,
	output logic [exec_pkg::XLEN-1:0] o_sum,
	output logic o_compare
);

	localparam int SHAMT_W = $clog2(exec_pkg::XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic [exec_pkg::XLEN-1:0] sum;
	logic [exec_pkg::XLEN-1:0] diff;
	logic equal;
	logic less_signed;
	logic less_unsigned;

	assign shamt = i_op2[SHAMT_W-1:0];
	assign sum = i_op1 + i_op2;
	assign diff = i_op1 - i_op2;
	assign equal = (i_op1 == i_op2);
	assign less_signed = ($signed(i_op1) < $signed(i_op2));
	assign less_unsigned = (i_op1 < i_op2);

	// Address and jump target adder
	assign o_sum = sum;

	// Compare bit, shared by branches and set-less-than
	always_comb begin
		case (i_op)
		exec_pkg::ALU_EQ: o_compare = equal;
		exec_pkg::ALU_NE: o_compare = !equal;
		exec_pkg::ALU_LT: o_compare = less_signed;
		exec_pkg::ALU_LTU: o_compare = less_unsigned;
		exec_pkg::ALU_GE: o_compare = !less_signed;
		exec_pkg::ALU_GEU: o_compare = !less_unsigned;
		default: o_compare = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
		exec_pkg::ALU_ADD: o_result = sum;
		exec_pkg::ALU_SUB: o_result = diff;
		exec_pkg::ALU_AND: o_result = i_op1 & i_op2;
		exec_pkg::ALU_OR: o_result = i_op1 | i_op2;
		exec_pkg::ALU_XOR: o_result = i_op1 ^ i_op2;
		exec_pkg::ALU_SLL: o_result = i_op1 << shamt;
		exec_pkg::ALU_SRL: o_result = i_op1 >> shamt;
		exec_pkg::ALU_SRA: o_result = $unsigned($signed(i_op1) >>> shamt);
		// Compare ops write 0 or 1 to rd
		default: o_result = {{(exec_pkg::XLEN-1){1'b0}}, o_compare};
		endcase
	end

endmodule

//--- design/exec_pkg.sv
// Execute stage shared types
package exec_pkg;

	// ============================================================
	// Widths
	// ============================================================

	localparam int XLEN = 32;
	localparam int REG_W = 5;

	// Multiplier depth used when the top level is not overridden
	localparam int MUL_STAGES_DEFAULT = 2;

	// ============================================================
	// Encodings
	// ============================================================

	// Zero is illegal so that a cleared issue word faults
	typedef enum logic [3:0] {
		CLASS_NONE,
		CLASS_ARITH,
		CLASS_SHIFT,
		CLASS_COMPARE,
		CLASS_JUMP,
		CLASS_BRANCH,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_MULDIV
	} exec_class_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_LTU,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_ZERO,
		SEL_RS1,
		SEL_RS2,
		SEL_PC,
		SEL_IMM
	} operand_sel_e;

	typedef enum logic [2:0] {
		MD_MUL,
		MD_MULH,
		MD_MULHU,
		MD_DIV,
		MD_DIVU,
		MD_REM,
		MD_REMU
	} muldiv_op_e;

	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} mem_width_e;

	// ============================================================
	// Bundles
	// ============================================================

	typedef struct packed {
		logic strobe;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		logic [REG_W-1:0] rd;
		exec_class_e op_class;
		alu_op_e alu_op;
		operand_sel_e op1_sel;
		operand_sel_e op2_sel;
		muldiv_op_e muldiv_op;
		mem_width_e mem_width;
		logic mem_signed;
	} exec_issue_t;

	typedef struct packed {
		logic strobe;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0] rd_value;
		logic mem_read;
		logic mem_write;
		logic [XLEN-1:0] mem_address;
		mem_width_e mem_width;
		logic mem_signed;
	} exec_result_t;

	typedef struct packed {
		logic is_signed;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
	} muldiv_req_t;

endpackage
